// ==== kalman_defs.svh ====
`ifndef KALMAN_DEFS_SVH
`define KALMAN_DEFS_SVH

// number of resonators, one per tracked harmonic.
`define HARMONICS_NUM 4

// signed q1.17 word.
`define FX_WIDTH 18
`define FX_FRAC 17

`endif

// ==== kalman_pkg.sv ====
`include "kalman_defs.svh"

package kalman_pkg;

	typedef logic signed [`FX_WIDTH-1:0] fx_t;
	typedef logic [$clog2(`HARMONICS_NUM)-1:0] harm_idx_t;

	typedef enum logic [1:0] {
		COEF_COS = 2'd0,
		COEF_SIN = 2'd1,
		COEF_K1 = 2'd2,
		COEF_K2 = 2'd3
	} coef_field_e;

	typedef struct packed {
		logic wr;
		harm_idx_t harm;
		coef_field_e field;
		fx_t data;
	} coef_wr_t;

	typedef struct packed {
		fx_t cos;
		fx_t sin;
		fx_t k1;
		fx_t k2;
	} harm_coef_t;

	typedef enum logic [2:0] {
		OP_IDLE = 3'd0,
		OP_CLR_SUM = 3'd1,
		OP_PREDICT = 3'd2,
		OP_ERROR = 3'd3,
		OP_CORRECT = 3'd4
	} mac_op_e;

	typedef enum logic [2:0] {
		S_IDLE = 3'd0,
		S_CLEAR = 3'd1,
		S_PREDICT = 3'd2,
		S_ERROR = 3'd3,
		S_CORRECT = 3'd4
	} seq_state_e;

	typedef struct packed {
		mac_op_e op;
		harm_idx_t harm;
	} mac_cmd_t;

	typedef struct packed {
		logic valid;
		harm_idx_t harm;
		fx_t amp;
	} amp_wr_t;

endpackage

// ==== coef_bank.sv ====
`include "kalman_defs.svh"

module coef_bank (
	input  logic                   clk_i,
	input  logic                   harmonics_rst,
	input  kalman_pkg::coef_wr_t   coef_wr_i,
	input  logic                   enable_i,
	input  logic                   busy_i,
	input  kalman_pkg::fx_t        sample_i,
	input  kalman_pkg::harm_idx_t  harm_i,
	output kalman_pkg::harm_coef_t coef_o,
	output kalman_pkg::fx_t        sample_o
);

	kalman_pkg::harm_coef_t coef_q [`HARMONICS_NUM];
	kalman_pkg::fx_t sample_q;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int i = 0; i < `HARMONICS_NUM; i++) begin
				coef_q[i] <= '0;
			end
		end else if (coef_wr_i.wr) begin
			case (coef_wr_i.field) // one field per write.
				kalman_pkg::COEF_COS: begin
					coef_q[coef_wr_i.harm].cos <= coef_wr_i.data;
				end
				kalman_pkg::COEF_SIN: begin
					coef_q[coef_wr_i.harm].sin <= coef_wr_i.data;
				end
				kalman_pkg::COEF_K1: begin
					coef_q[coef_wr_i.harm].k1 <= coef_wr_i.data;
				end
				default: begin
					coef_q[coef_wr_i.harm].k2 <= coef_wr_i.data;
				end
			endcase
		end
	end

	// sample is only taken when an update is accepted.
	always_ff @(posedge clk_i) begin
		if (enable_i && !busy_i) begin
			sample_q <= sample_i;
		end
	end

	assign coef_o = coef_q[harm_i]; // follows current command.
	assign sample_o = sample_q;

endmodule

// ==== harmonic_seq.sv ====
`include "kalman_defs.svh"

module harmonic_seq (
	input  logic                 clk_i,
	input  logic                 harmonics_rst,
	input  logic                 enable_i,
	output logic                 busy_o,
	output kalman_pkg::mac_cmd_t cmd_o
);

	localparam kalman_pkg::harm_idx_t LAST_HARM =
		kalman_pkg::harm_idx_t'(`HARMONICS_NUM - 1);

	kalman_pkg::seq_state_e state_q;
	kalman_pkg::seq_state_e state_d;
	kalman_pkg::harm_idx_t harm_q;
	kalman_pkg::harm_idx_t harm_d;
	logic last_harm;

	// compare against the count, the index need not wrap.
	assign last_harm = (harm_q == LAST_HARM);

	always_comb begin
		state_d = state_q;
		harm_d = harm_q;
		cmd_o.op = kalman_pkg::OP_IDLE;
		cmd_o.harm = harm_q;
		case (state_q)
			kalman_pkg::S_IDLE: begin
				harm_d = '0;
				if (enable_i) begin
					state_d = kalman_pkg::S_CLEAR;
				end
			end
			kalman_pkg::S_CLEAR: begin
				cmd_o.op = kalman_pkg::OP_CLR_SUM;
				state_d = kalman_pkg::S_PREDICT;
			end
			kalman_pkg::S_PREDICT: begin
				cmd_o.op = kalman_pkg::OP_PREDICT;
				if (last_harm) begin
					harm_d = '0;
					state_d = kalman_pkg::S_ERROR;
				end else begin
					harm_d = harm_q + 1'b1;
				end
			end
			kalman_pkg::S_ERROR: begin
				cmd_o.op = kalman_pkg::OP_ERROR;
				state_d = kalman_pkg::S_CORRECT;
			end
			kalman_pkg::S_CORRECT: begin
				cmd_o.op = kalman_pkg::OP_CORRECT;
				if (last_harm) begin
					harm_d = '0;
					state_d = kalman_pkg::S_IDLE;
				end else begin
					harm_d = harm_q + 1'b1;
				end
			end
			default: begin
				harm_d = '0;
				state_d = kalman_pkg::S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q <= kalman_pkg::S_IDLE;
			harm_q <= '0;
		end else begin
			state_q <= state_d;
			harm_q <= harm_d;
		end
	end

	assign busy_o = (state_q != kalman_pkg::S_IDLE); // 2n+2 cycles per update.

endmodule

// ==== state_mac.sv ====
`include "kalman_defs.svh"

module state_mac (
	input  logic                   clk_i,
	input  logic                   harmonics_rst,
	input  kalman_pkg::mac_cmd_t   cmd_i,
	input  kalman_pkg::harm_coef_t coef_i,
	input  kalman_pkg::fx_t        sample_i,
	output kalman_pkg::fx_t        err_o,
	output kalman_pkg::amp_wr_t    amp_wr_o
);

	// full product, arithmetic shift floors it back to q1.17.
	function automatic kalman_pkg::fx_t fx_mul(input kalman_pkg::fx_t a,
		input kalman_pkg::fx_t b);
		logic signed [2*`FX_WIDTH-1:0] prod;
		prod = a * b;
		return kalman_pkg::fx_t'(prod >>> `FX_FRAC);
	endfunction

	kalman_pkg::fx_t x1_q [`HARMONICS_NUM];
	kalman_pkg::fx_t x2_q [`HARMONICS_NUM];
	kalman_pkg::fx_t sum_q;
	kalman_pkg::fx_t err_q;
	kalman_pkg::amp_wr_t amp_wr_q;

	kalman_pkg::fx_t x1_cur;
	kalman_pkg::fx_t x2_cur;
	kalman_pkg::fx_t x1_pred;
	kalman_pkg::fx_t x2_pred;
	kalman_pkg::fx_t x1_corr;
	kalman_pkg::fx_t x2_corr;
	kalman_pkg::fx_t amp_calc;

	assign x1_cur = x1_q[cmd_i.harm];
	assign x2_cur = x2_q[cmd_i.harm];

	// rotation by the harmonic's cos/sin.
	assign x1_pred = fx_mul(x1_cur, coef_i.cos) - fx_mul(x2_cur, coef_i.sin);
	assign x2_pred = fx_mul(x1_cur, coef_i.sin) + fx_mul(x2_cur, coef_i.cos);

	assign amp_calc = fx_mul(x1_cur, x1_cur) + fx_mul(x2_cur, x2_cur); // predicted state.
	assign x1_corr = x1_cur + fx_mul(coef_i.k1, err_q);
	assign x2_corr = x2_cur + fx_mul(coef_i.k2, err_q);

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int i = 0; i < `HARMONICS_NUM; i++) begin
				x1_q[i] <= '0;
				x2_q[i] <= '0;
			end
			sum_q <= '0;
			err_q <= '0;
			amp_wr_q <= '0;
		end else begin
			amp_wr_q.valid <= 1'b0;
			case (cmd_i.op)
				kalman_pkg::OP_CLR_SUM: begin
					sum_q <= '0;
				end
				kalman_pkg::OP_PREDICT: begin
					x1_q[cmd_i.harm] <= x1_pred;
					x2_q[cmd_i.harm] <= x2_pred;
					sum_q <= sum_q + x1_pred;
				end
				kalman_pkg::OP_ERROR: begin
					err_q <= sample_i - sum_q;
				end
				kalman_pkg::OP_CORRECT: begin
					x1_q[cmd_i.harm] <= x1_corr;
					x2_q[cmd_i.harm] <= x2_corr;
					amp_wr_q.valid <= 1'b1;
					amp_wr_q.harm <= cmd_i.harm;
					amp_wr_q.amp <= amp_calc;
				end
				default: begin
				end
			endcase
		end
	end

	assign err_o = err_q;
	assign amp_wr_o = amp_wr_q;

endmodule

// ==== spectrum_out.sv ====
`include "kalman_defs.svh"

module spectrum_out (
	input  logic                  clk_i,
	input  logic                  harmonics_rst,
	input  kalman_pkg::amp_wr_t   amp_wr_i,
	input  kalman_pkg::harm_idx_t amp_rd_addr_i,
	output kalman_pkg::fx_t       amp_o
);

	kalman_pkg::fx_t amp_tab [`HARMONICS_NUM];
	kalman_pkg::fx_t amp_q;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int i = 0; i < `HARMONICS_NUM; i++) begin
				amp_tab[i] <= '0;
			end
		end else if (amp_wr_i.valid) begin
			amp_tab[amp_wr_i.harm] <= amp_wr_i.amp;
		end
	end

	// registered read, one cycle after the address.
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			amp_q <= '0;
		end else begin
			amp_q <= amp_tab[amp_rd_addr_i];
		end
	end

	assign amp_o = amp_q;

endmodule

// ==== kalman_top.sv ====
module kalman_top (
	input  logic                  clk_i,
	input  logic                  harmonics_rst,
	input  kalman_pkg::coef_wr_t  coef_wr_i,
	input  kalman_pkg::fx_t       sample_i,
	input  logic                  enable_i,
	input  kalman_pkg::harm_idx_t amp_rd_addr_i,
	output logic                  busy_o,
	output kalman_pkg::fx_t       err_o,
	output kalman_pkg::fx_t       amp_o
);

	kalman_pkg::mac_cmd_t cmd;
	kalman_pkg::harm_coef_t coef;
	kalman_pkg::fx_t sample;
	kalman_pkg::amp_wr_t amp_wr;

	coef_bank u_coef_bank (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.coef_wr_i     (coef_wr_i),
		.enable_i      (enable_i),
		.busy_i        (busy_o),
		.sample_i      (sample_i),
		.harm_i        (cmd.harm),
		.coef_o        (coef),
		.sample_o      (sample)
	);

	harmonic_seq u_harmonic_seq (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.enable_i      (enable_i),
		.busy_o        (busy_o),
		.cmd_o         (cmd)
	);

	state_mac u_state_mac (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.cmd_i         (cmd),
		.coef_i        (coef),
		.sample_i      (sample),
		.err_o         (err_o),
		.amp_wr_o      (amp_wr)
	);

	spectrum_out u_spectrum_out (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.amp_wr_i      (amp_wr),
		.amp_rd_addr_i (amp_rd_addr_i),
		.amp_o         (amp_o)
	);

endmodule

// ==== tb_kalman_model.svh ====
`ifndef TB_KALMAN_MODEL_SVH
`define TB_KALMAN_MODEL_SVH

kalman_pkg::fx_t model_x1 [`HARMONICS_NUM];
kalman_pkg::fx_t model_x2 [`HARMONICS_NUM];
kalman_pkg::harm_coef_t model_coef [`HARMONICS_NUM];

// a*b >> 17 on the full product, left unwrapped.
function automatic longint floor_mul(input kalman_pkg::fx_t a, input kalman_pkg::fx_t b);
	longint full;
	full = longint'(a) * longint'(b);
	return full >>> `FX_FRAC;
endfunction

function automatic kalman_pkg::fx_t wrap_fx(input longint v);
	return kalman_pkg::fx_t'(v[`FX_WIDTH-1:0]); // keep low 18 bits.
endfunction

// one full update: rotate, sum, error, amplitude, correct.
task automatic advance_model(input kalman_pkg::fx_t sample, output kalman_pkg::fx_t err,
	output kalman_pkg::fx_t [`HARMONICS_NUM-1:0] amps);
	longint sum;
	kalman_pkg::fx_t x1;
	kalman_pkg::fx_t x2;
	kalman_pkg::harm_coef_t c;
	sum = 0;
	for (int h = 0; h < `HARMONICS_NUM; h++) begin
		x1 = model_x1[h];
		x2 = model_x2[h];
		c = model_coef[h];
		model_x1[h] = wrap_fx(floor_mul(x1, c.cos) - floor_mul(x2, c.sin));
		model_x2[h] = wrap_fx(floor_mul(x1, c.sin) + floor_mul(x2, c.cos));
		sum += model_x1[h];
	end
	err = wrap_fx(longint'(sample) - sum);
	for (int h = 0; h < `HARMONICS_NUM; h++) begin
		x1 = model_x1[h];
		x2 = model_x2[h];
		c = model_coef[h];
		amps[h] = wrap_fx(floor_mul(x1, x1) + floor_mul(x2, x2)); // before correction.
		model_x1[h] = wrap_fx(x1 + floor_mul(c.k1, err));
		model_x2[h] = wrap_fx(x2 + floor_mul(c.k2, err));
	end
endtask

`endif

// ==== tb_kalman.sv ====
`include "kalman_defs.svh"

module tb_kalman;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 16;
	localparam int NUM_ENTRIES = 12;
	localparam int RELOAD_AT = NUM_ENTRIES / 2;
	localparam int BUSY_CYCLES = 2 * `HARMONICS_NUM + 2;
	localparam longint WATCHDOG_TIME = (NUM_ENTRIES * (BUSY_CYCLES + `HARMONICS_NUM + 10)
		+ RST_CYCLES + 5 * `HARMONICS_NUM + 4) * CLK_PERIOD;

	typedef struct packed {
		logic reload;
		logic stray;
		kalman_pkg::harm_idx_t reload_harm;
		kalman_pkg::harm_coef_t reload_coef;
		kalman_pkg::fx_t sample;
		kalman_pkg::fx_t exp_err;
		kalman_pkg::fx_t [`HARMONICS_NUM-1:0] exp_amp;
	} stim_entry_t;

	logic clk_i;
	logic harmonics_rst;
	kalman_pkg::coef_wr_t coef_wr_i;
	kalman_pkg::fx_t sample_i;
	logic enable_i;
	kalman_pkg::harm_idx_t amp_rd_addr_i;
	logic busy_o;
	kalman_pkg::fx_t err_o;
	kalman_pkg::fx_t amp_o;

	stim_entry_t stim_tab [NUM_ENTRIES];
	kalman_pkg::harm_coef_t init_coef [`HARMONICS_NUM];

	`include "tb_kalman_model.svh"

	kalman_top dut (.*);

	initial begin
		clk_i = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_i = ~clk_i;
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: busy_o never fell, the update did not finish in time");
		$display("test failed");
		$fatal(1);
	end

	task automatic abort_run(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_fx(input string name, input kalman_pkg::fx_t got,
		input kalman_pkg::fx_t exp);
		if (got !== exp) begin
			abort_run(name, 32'($unsigned(got)), 32'($unsigned(exp)));
		end
	endtask

	task automatic check_busy(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run(name, 32'(got), 32'(exp));
		end
	endtask

	task automatic expect_len(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run(name, got, exp);
		end
	endtask

	function automatic kalman_pkg::harm_coef_t draw_coefs();
		kalman_pkg::fx_t v [4];
		for (int f = 0; f < 4; f++) begin
			v[f] = kalman_pkg::fx_t'(int'($urandom % 65536) - 32768); // within +-0.25.
		end
		return {v[0], v[1], v[2], v[3]};
	endfunction

	task automatic load_coef(input kalman_pkg::harm_idx_t h, input kalman_pkg::harm_coef_t c);
		kalman_pkg::fx_t vals [4];
		vals = '{c.cos, c.sin, c.k1, c.k2};
		for (int f = 0; f < 4; f++) begin
			@(negedge clk_i);
			coef_wr_i = '{wr: 1'b1, harm: h, field: kalman_pkg::coef_field_e'(f), data: vals[f]};
		end
		@(negedge clk_i);
		coef_wr_i = '0;
	endtask

	// called on a falling edge, one address per cycle.
	task automatic read_amps(input kalman_pkg::fx_t [`HARMONICS_NUM-1:0] exp);
		for (int h = 0; h < `HARMONICS_NUM; h++) begin
			amp_rd_addr_i = kalman_pkg::harm_idx_t'(h);
			@(negedge clk_i);
			check_fx($sformatf("amp_o[%0d]", h), amp_o, exp[h]);
		end
	endtask

	task automatic run_update(input stim_entry_t e);
		int n;
		n = 0;
		@(negedge clk_i);
		sample_i = e.sample;
		enable_i = 1'b1;
		@(negedge clk_i);
		enable_i = 1'b0;
		if (e.stray) begin
			sample_i = ~e.sample; // must not reach the capture register.
		end
		check_busy("busy_o", busy_o, 1'b1);
		while (busy_o) begin
			n++;
			enable_i = e.stray && (n == 3); // pulse while busy.
			@(negedge clk_i);
		end
		enable_i = 1'b0;
		expect_len("busy_o cycles", n, BUSY_CYCLES);
		check_fx("err_o", err_o, e.exp_err);
		read_amps(e.exp_amp);
	endtask

	initial begin
		void'($urandom(89520));
		harmonics_rst = 1'b1;
		enable_i = 1'b0;
		sample_i = '0;
		coef_wr_i = '0;
		amp_rd_addr_i = '0;
		for (int h = 0; h < `HARMONICS_NUM; h++) begin
			init_coef[h] = draw_coefs();
			model_coef[h] = init_coef[h];
			model_x1[h] = '0;
			model_x2[h] = '0;
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			stim_tab[i] = '0;
			stim_tab[i].sample = kalman_pkg::fx_t'($urandom);
			stim_tab[i].stray = (i % 3 == 1);
			if (i == RELOAD_AT) begin
				stim_tab[i].reload = 1'b1;
				stim_tab[i].reload_harm = kalman_pkg::harm_idx_t'($urandom % `HARMONICS_NUM);
				stim_tab[i].reload_coef = draw_coefs();
				model_coef[stim_tab[i].reload_harm] = stim_tab[i].reload_coef;
			end
			advance_model(stim_tab[i].sample, stim_tab[i].exp_err, stim_tab[i].exp_amp);
		end
		repeat (RST_CYCLES) @(negedge clk_i);
		harmonics_rst = 1'b0;
		@(negedge clk_i);
		check_busy("busy_o", busy_o, 1'b0);
		check_fx("err_o", err_o, '0);
		read_amps('0);
		for (int h = 0; h < `HARMONICS_NUM; h++) begin
			load_coef(kalman_pkg::harm_idx_t'(h), init_coef[h]);
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (stim_tab[i].reload) begin
				load_coef(stim_tab[i].reload_harm, stim_tab[i].reload_coef);
			end
			run_update(stim_tab[i]);
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
kalman_pkg.sv
coef_bank.sv
harmonic_seq.sv
state_mac.sv
spectrum_out.sv
kalman_top.sv
tb_kalman.sv

// ==== Bender.yml ====
package:
  name: harmonic_kalman

export_include_dirs:
  - .

sources:
  - kalman_pkg.sv
  - coef_bank.sv
  - harmonic_seq.sv
  - state_mac.sv
  - spectrum_out.sv
  - kalman_top.sv
  - target: test
    files:
      - tb_kalman.sv
